/* src/adxl_pkg.sv */
package adxl_pkg;

    localparam int REG_WORDS   = 16;             // 32-bit words in shadow and readback maps
    localparam int WORD_ADDR_W = 4;
    localparam int BYTE_ADDR_W = 6;

    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_PTR_W  = 4;

    // lane k of word w is device byte address w*4+k
    localparam logic [REG_WORDS-1:0][3:0] WRITE_MASK = {
        4'b0000,                                   // word 15, 0x3C
        4'b0001,                                   // word 14, 0x38
        4'b0000,                                   // word 13, 0x34
        4'b0100,                                   // word 12, 0x30
        4'b1111,                                   // word 11, 0x2C
        4'b1110,                                   // word 10, 0x28
        4'b1111,                                   // word 9, 0x24
        4'b1111,                                   // word 8, 0x20
        4'b0111,                                   // word 7, 0x1C
        {7{4'b0000}}                               // words 6 down to 0
    };

    localparam logic [BYTE_ADDR_W-1:0] UPD_FIRST = 6'h1D;
    localparam logic [BYTE_ADDR_W-1:0] UPD_LAST  = 6'h38;
    localparam logic [7:0]             READ_LEN  = 8'h3A;

    typedef struct packed {
        logic [31:0]            data;
        logic [3:0]             strb;
        logic [WORD_ADDR_W-1:0] addr;
        logic                   valid;
    } host_wr_t;

    typedef struct packed {
        logic [7:0] data;
        logic [6:0] dev_addr;                      // i2c device address
        logic       rd;                            // 1 = read command
        logic       last;
    } cmd_beat_t;

    typedef logic [REG_WORDS*4-1:0] dirty_t;       // one bit per map byte

endpackage

/* src/adxl_reg_shadow.sv */
`timescale 1ns/1ns

module adxl_reg_shadow
    import adxl_pkg::*;
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  host_wr_t               wr,
    input  logic [BYTE_ADDR_W-1:0] rd_addr,
    input  logic                   clr,
    output logic [7:0]             rd_data,
    output dirty_t                 dirty
);

    logic [REG_WORDS-1:0][3:0][7:0] shadow;      // device register image
    logic [3:0]                     lane_we;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lane_we[k] = wr.valid && wr.strb[k] && WRITE_MASK[wr.addr][k];
        end
    end

    // byte lanes written independently
    always_ff @(posedge CLK) begin
        for (int k = 0; k < 4; k++) begin
            if (lane_we[k]) begin
                shadow[wr.addr][k] <= wr.data[k*8 +: 8];
            end
        end
    end

    // a host write in the clear cycle keeps the byte dirty
    always_ff @(posedge CLK) begin
        if (RESET) begin
            dirty <= '0;
        end else begin
            if (clr) begin
                dirty[rd_addr] <= 1'b0;
            end
            for (int k = 0; k < 4; k++) begin
                if (lane_we[k]) begin
                    dirty[{wr.addr, 2'(k)}] <= 1'b1;
                end
            end
        end
    end

    assign rd_data = shadow[rd_addr[BYTE_ADDR_W-1:2]][rd_addr[1:0]]; // same-cycle byte read

endmodule

/* src/adxl_cmd_sequencer.sv */
`timescale 1ns/1ns

module adxl_cmd_sequencer
    import adxl_pkg::*;
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  dirty_t                 dirty,
    input  logic [7:0]             rd_data,
    output logic [BYTE_ADDR_W-1:0] rd_addr,
    output logic                   clr,
    input  logic [6:0]             i2c_address,
    input  logic                   interval_enable,
    input  logic [31:0]            request_interval,
    input  logic                   single_request,
    output logic                   single_request_complete,
    output cmd_beat_t              cmd,
    output logic                   push,
    input  logic                   full,
    output logic                   arm,
    input  logic                   done
);

    typedef enum logic [2:0] {
        st_idle,
        st_upd_chk,
        st_upd_send,
        st_req_ptr,
        st_req_read,
        st_req_wait
    } state_t;

    state_t                 state;
    logic [BYTE_ADDR_W-1:0] addr;                // scan pointer
    logic [1:0]             beat_cnt;
    logic [31:0]            timer;
    logic                   timer_hit;
    dirty_t                 pending;             // dirty bytes inside the scan window

    always_comb begin
        for (int i = 0; i < REG_WORDS*4; i++) begin
            pending[i] = dirty[i] && (i >= UPD_FIRST) && (i <= UPD_LAST);
        end
    end

    assign rd_addr   = addr;
    assign timer_hit = (state == st_idle) && interval_enable && (timer == '0);
    assign push      = (state inside {st_upd_send, st_req_ptr, st_req_read}) && !full;
    assign clr       = push && (state == st_upd_send) && (beat_cnt == 2'd2);
    assign arm       = push && (state == st_req_read);

    always_comb begin
        cmd.data     = 8'h01;                    // byte count beat
        cmd.dev_addr = i2c_address;
        cmd.rd       = 1'b0;
        cmd.last     = 1'b0;
        case (state)
            st_upd_send: begin
                if (beat_cnt == 2'd1) begin
                    cmd.data = {2'b00, addr};
                end else if (beat_cnt == 2'd2) begin
                    cmd.data = rd_data;
                    cmd.last = 1'b1;
                end
            end
            st_req_ptr: begin
                if (beat_cnt == 2'd1) begin
                    cmd.data = 8'h00;            // register pointer
                    cmd.last = 1'b1;
                end
            end
            st_req_read: begin
                cmd.data = READ_LEN;
                cmd.rd   = 1'b1;
                cmd.last = 1'b1;
            end
            default: ;
        endcase
    end

    // counts only while idle and enabled
    always_ff @(posedge CLK) begin
        if (RESET) begin
            timer <= '0;
        end else if ((state != st_idle) || !interval_enable) begin
            timer <= request_interval;
        end else if (timer != '0) begin
            timer <= timer - 32'd1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state                   <= st_idle;
            addr                    <= UPD_FIRST;
            beat_cnt                <= '0;
            single_request_complete <= 1'b0;
        end else begin
            single_request_complete <= arm && single_request;
            case (state)
                st_idle: begin
                    addr     <= UPD_FIRST;
                    beat_cnt <= '0;
                    if (|pending) begin
                        state <= st_upd_chk;       // updates win over readout
                    end else if (single_request || timer_hit) begin
                        state <= st_req_ptr;
                    end
                end
                st_upd_chk: begin
                    if (pending[addr]) begin
                        state <= st_upd_send;
                    end else if (addr == UPD_LAST) begin
                        state <= st_idle;
                    end else begin
                        addr <= addr + 1'b1;
                    end
                end
                st_upd_send: begin
                    if (push) begin
                        if (beat_cnt == 2'd2) begin
                            beat_cnt <= '0;
                            if (addr == UPD_LAST) begin
                                state <= st_idle;
                            end else begin
                                addr  <= addr + 1'b1;
                                state <= st_upd_chk;
                            end
                        end else begin
                            beat_cnt <= beat_cnt + 2'd1;
                        end
                    end
                end
                st_req_ptr: begin
                    if (push) begin
                        if (beat_cnt == 2'd1) begin
                            beat_cnt <= '0;
                            state    <= st_req_read;
                        end else begin
                            beat_cnt <= beat_cnt + 2'd1;
                        end
                    end
                end
                st_req_read: begin
                    if (push) begin
                        state <= st_req_wait;
                    end
                end
                st_req_wait: begin
                    if (done) begin
                        state <= st_idle;  // readback fully captured
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* src/adxl_cmd_fifo.sv */
`timescale 1ns/1ns

module adxl_cmd_fifo
    import adxl_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  cmd_beat_t cmd,
    input  logic      push,
    output logic      full,
    output cmd_beat_t m_beat,
    output logic      m_tvalid,
    input  logic      m_tready
);

    cmd_beat_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wptr;
    logic [FIFO_PTR_W-1:0] rptr;
    logic [FIFO_PTR_W:0]   count;                // one extra bit for the full case
    logic                  wr_en;
    logic                  rd_en;

    assign full     = (count == FIFO_DEPTH);
    assign m_tvalid = (count != '0);
    assign m_beat   = mem[rptr];                 // head beat holds until popped
    assign wr_en    = push && !full;
    assign rd_en    = m_tvalid && m_tready;

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wptr] <= cmd;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + 1'b1;
            end
            if (rd_en) begin
                rptr <= rptr + 1'b1;
            end
            count <= count + (FIFO_PTR_W+1)'(wr_en) - (FIFO_PTR_W+1)'(rd_en);
        end
    end

endmodule

/* src/adxl_rx_capture.sv */
`timescale 1ns/1ns

module adxl_rx_capture
    import adxl_pkg::*;
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   arm,
    input  logic [7:0]             s_tdata,
    input  logic                   s_tvalid,
    input  logic                   s_tlast,
    output logic                   done,
    input  logic [WORD_ADDR_W-1:0] raddr,
    output logic [31:0]            rdata
);

    logic [REG_WORDS-1:0][3:0][7:0] rb_mem;      // readback image
    logic [BYTE_ADDR_W-1:0]         ptr;
    logic                           armed;
    logic                           wr_en;

    assign wr_en = armed && s_tvalid;            // never stalls the device side
    assign done  = wr_en && s_tlast;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            armed <= 1'b0;
            ptr   <= '0;
        end else if (arm) begin
            armed <= 1'b1;
            ptr   <= '0;
        end else if (wr_en) begin
            ptr <= ptr + 1'b1;
            if (s_tlast) begin
                armed <= 1'b0;
            end
        end
    end

    // byte i lands in word i/4, lane i%4
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            rb_mem[ptr[BYTE_ADDR_W-1:2]][ptr[1:0]] <= s_tdata;
        end
    end

    always_ff @(posedge CLK) begin
        rdata <= rb_mem[raddr];                  // one cycle read latency
    end

endmodule

/* src/adxl_top.sv */
`timescale 1ns/1ns

module adxl_top
    import adxl_pkg::*;
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic [WORD_ADDR_W-1:0] waddr,
    input  logic                   wvalid,
    input  logic [WORD_ADDR_W-1:0] raddr,
    output logic [31:0]            rdata,
    input  logic [6:0]             i2c_address,
    input  logic                   interval_enable,
    input  logic [31:0]            request_interval,
    input  logic                   single_request,
    output logic                   single_request_complete,
    output logic [7:0]             m_tdata,
    output logic [7:0]             m_tuser,
    output logic                   m_tvalid,
    output logic                   m_tlast,
    input  logic                   m_tready,
    input  logic [7:0]             s_tdata,
    input  logic                   s_tvalid,
    input  logic                   s_tlast
);

    host_wr_t               host_wr;
    dirty_t                 dirty;
    logic [BYTE_ADDR_W-1:0] rd_addr;
    logic [7:0]             rd_data;
    logic                   clr;
    cmd_beat_t              cmd;
    logic                   push;
    logic                   full;
    cmd_beat_t              m_beat;
    logic                   arm;
    logic                   done;

    assign host_wr = '{data: wdata, strb: wstrb, addr: waddr, valid: wvalid};

    assign m_tdata = m_beat.data;
    assign m_tuser = {m_beat.dev_addr, m_beat.rd}; // address high, direction in bit 0
    assign m_tlast = m_beat.last;

    adxl_reg_shadow u_reg_shadow (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (host_wr),
        .rd_addr (rd_addr),
        .clr     (clr),
        .rd_data (rd_data),
        .dirty   (dirty)
    );

    adxl_cmd_sequencer u_cmd_sequencer (
        .CLK                     (CLK),
        .RESET                   (RESET),
        .dirty                   (dirty),
        .rd_data                 (rd_data),
        .rd_addr                 (rd_addr),
        .clr                     (clr),
        .i2c_address             (i2c_address),
        .interval_enable         (interval_enable),
        .request_interval        (request_interval),
        .single_request          (single_request),
        .single_request_complete (single_request_complete),
        .cmd                     (cmd),
        .push                    (push),
        .full                    (full),
        .arm                     (arm),
        .done                    (done)
    );

    adxl_cmd_fifo u_cmd_fifo (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd      (cmd),
        .push     (push),
        .full     (full),
        .m_beat   (m_beat),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

    adxl_rx_capture u_rx_capture (
        .CLK      (CLK),
        .RESET    (RESET),
        .arm      (arm),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tlast  (s_tlast),
        .done     (done),
        .raddr    (raddr),
        .rdata    (rdata)
    );

endmodule

/* dv/adxl_top_assertions.sv */
`timescale 1ns/1ns

module adxl_top_assertions (
    input logic       CLK,
    input logic       RESET,
    input logic       m_tvalid,
    input logic       m_tready,
    input logic [7:0] m_tdata,
    input logic [7:0] m_tuser,
    input logic       m_tlast,
    input logic       single_request_complete
);

    int error_count = 0;                           // failures seen so far

    valid_after_reset: assert property (@(posedge CLK) $fell(RESET) |-> !m_tvalid)
        else begin
            error_count++;
            $error("m_tvalid high in the cycle after reset release");
        end

    // stalled beat must not change
    stall_holds: assert property (@(posedge CLK) disable iff (RESET)
        m_tvalid && !m_tready |=>
            m_tvalid && $stable(m_tdata) && $stable(m_tuser) && $stable(m_tlast))
        else begin
            error_count++;
            $error("stalled beat changed before it was accepted");
        end

    complete_pulse: assert property (@(posedge CLK) disable iff (RESET)
        single_request_complete |=> !single_request_complete)
        else begin
            error_count++;
            $error("single_request_complete lasted two cycles");
        end

endmodule

/* dv/tb_adxl_top.sv */
`timescale 1ns/1ns

module tb_adxl_top;

    localparam int         TIMEOUT_CYCLES = 20000;  // whole run needs a few thousand
    localparam int         RX_BYTES       = 'h3A;   // bytes per readout
    localparam logic [6:0] DEV_ADDR       = 7'h53;

    logic        CLK = 1'b0;
    logic        RESET;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [3:0]  waddr;
    logic        wvalid;
    logic [3:0]  raddr;
    logic [31:0] rdata;
    logic [6:0]  i2c_address;
    logic        interval_enable;
    logic [31:0] request_interval;
    logic        single_request;
    logic        single_request_complete;
    logic [7:0]  m_tdata;
    logic [7:0]  m_tuser;
    logic        m_tvalid;
    logic        m_tlast;
    logic        m_tready;
    logic [7:0]  s_tdata;
    logic        s_tvalid;
    logic        s_tlast;

    integer      seed = 32'hd950_482c;
    logic [16:0] expected [$];                     // {data, user, last}
    logic [16:0] exp_beat;
    logic        stall;                            // forces m_tready low
    int          responses;

    adxl_top u_dut (.*);

    bind adxl_top adxl_top_assertions u_assertions (
        .CLK                     (CLK),
        .RESET                   (RESET),
        .m_tvalid                (m_tvalid),
        .m_tready                (m_tready),
        .m_tdata                 (m_tdata),
        .m_tuser                 (m_tuser),
        .m_tlast                 (m_tlast),
        .single_request_complete (single_request_complete)
    );

    always #10 CLK = ~CLK;

    function automatic logic mask_allows(input logic [5:0] a);
        return a inside {[6'h1C:6'h1E], [6'h20:6'h27], [6'h29:6'h2F], 6'h32, 6'h38};
    endfunction

    function automatic logic [16:0] beat_of(input logic [7:0] data, input logic rd,
                                            input logic last);
        return {data, DEV_ADDR, rd, last};
    endfunction

    task automatic stop_failed();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    // called 2 ns after an edge, returns at the same point
    task automatic host_write(input logic [3:0] word, input logic [3:0] strb,
                              input logic [31:0] data);
        logic [5:0] a;
        wdata  = data;
        wstrb  = strb;
        waddr  = word;
        wvalid = 1'b1;
        for (int k = 0; k < 4; k++) begin
            a = {word, 2'(k)};
            if (strb[k] && mask_allows(a) && a >= 6'h1D && a <= 6'h38) begin
                expected.push_back(beat_of(8'h01, 1'b0, 1'b0));
                expected.push_back(beat_of({2'b00, a}, 1'b0, 1'b0));
                expected.push_back(beat_of(data[k*8 +: 8], 1'b0, 1'b1));
            end
        end
        @(posedge CLK);
        #2 wvalid = 1'b0;
    endtask

    // ascending words, so the scan never overtakes the writes
    task automatic write_block();
        host_write(4'd7,  4'b1011, $random(seed));
        host_write(4'd8,  4'b0101, $random(seed));
        host_write(4'd9,  4'b1111, $random(seed));
        host_write(4'd10, 4'b0011, $random(seed));
        host_write(4'd11, 4'b1100, $random(seed));
        host_write(4'd12, 4'b0110, $random(seed));
    endtask

    task automatic expect_readout();
        expected.push_back(beat_of(8'h01, 1'b0, 1'b0));
        expected.push_back(beat_of(8'h00, 1'b0, 1'b1));
        expected.push_back(beat_of(8'(RX_BYTES), 1'b1, 1'b1));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge CLK);
        #2;
    endtask

    task automatic wait_drain();
        while (expected.size() != 0) begin
            idle_cycles(1);
        end
    endtask

    task automatic wait_responses(input int n);
        while (responses < n) begin
            idle_cycles(1);
        end
    endtask

    task automatic check_readback();
        logic [7:0] b;
        for (int w = 0; w < 16; w++) begin
            raddr = 4'(w);
            idle_cycles(1);                        // rdata registered
            for (int k = 0; k < 4; k++) begin
                b = 8'(w*4 + k) ^ 8'h5A;
                if (w*4 + k < RX_BYTES) begin
                    assert (rdata[k*8 +: 8] == b)
                        else report_error($sformatf("readback word %0d lane %0d: got %h exp %h",
                                                    w, k, rdata[k*8 +: 8], b));
                end
            end
        end
    endtask

    always @(posedge CLK) begin
        #2;
        m_tready = stall ? 1'b0 : (($random(seed) & 3) != 0);
    end

    // scoreboard on accepted beats
    always @(posedge CLK) begin
        if (!RESET && m_tvalid && m_tready) begin
            assert (expected.size() != 0)
                else report_error($sformatf("unexpected beat %h/%h", m_tdata, m_tuser));
            if (expected.size() != 0) begin
                exp_beat = expected.pop_front();
                assert ({m_tdata, m_tuser, m_tlast} == exp_beat)
                    else report_error($sformatf("beat got %h exp %h",
                                                {m_tdata, m_tuser, m_tlast}, exp_beat));
            end
        end
    end

    // device answers each read command with byte i = i ^ 0x5A
    always @(posedge CLK) begin
        if (!RESET && m_tvalid && m_tready && m_tuser[0]) begin
            repeat (4) @(posedge CLK);
            for (int i = 0; i < RX_BYTES; i++) begin
                #2;
                s_tvalid = 1'b1;
                s_tdata  = 8'(i) ^ 8'h5A;
                s_tlast  = (i == RX_BYTES - 1);
                @(posedge CLK);
            end
            #2;
            s_tvalid  = 1'b0;
            s_tlast   = 1'b0;
            responses = responses + 1;
        end
    end

    always @(posedge CLK) begin
        if (u_dut.u_assertions.error_count != 0) begin
            $display("a protocol assertion on the DUT outputs failed");
            stop_failed();
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_failed();
    end

    initial begin
        RESET            = 1'b1;
        wdata            = '0;
        wstrb            = '0;
        waddr            = '0;
        wvalid           = 1'b0;
        raddr            = '0;
        i2c_address      = DEV_ADDR;
        interval_enable  = 1'b0;
        request_interval = 32'd50;
        single_request   = 1'b0;
        m_tready         = 1'b0;
        s_tdata          = '0;
        s_tvalid         = 1'b0;
        s_tlast          = 1'b0;
        stall            = 1'b1;
        responses        = 0;
        repeat (5) @(posedge CLK);
        #2 RESET = 1'b0;

        write_block();                             // fills the FIFO while stalled
        idle_cycles(40);
        stall = 1'b0;
        wait_drain();
        write_block();                             // same bytes dirty again
        wait_drain();
        idle_cycles(100);                          // nothing left to send

        expect_readout();
        single_request = 1'b1;
        while (!single_request_complete) begin
            idle_cycles(1);
        end
        single_request = 1'b0;
        wait_responses(1);
        check_readback();

        expect_readout();
        expect_readout();
        interval_enable = 1'b1;
        wait_drain();
        interval_enable = 1'b0;
        wait_responses(3);
        idle_cycles(200);

        if (u_dut.u_assertions.error_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("protocol assertions failed at end of run");
            stop_failed();
        end
    end

endmodule

/* verilog.f */
src/adxl_pkg.sv
src/adxl_reg_shadow.sv
src/adxl_cmd_sequencer.sv
src/adxl_cmd_fifo.sv
src/adxl_rx_capture.sv
src/adxl_top.sv
dv/adxl_top_assertions.sv
dv/tb_adxl_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_adxl_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation PASS" || (echo "simulation FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module adxl_top -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
